// File: neurram_ctrl_top.f
+incdir+dv
common/neurram_pkg.sv
source/array_mode_decode.sv
matmul/plane_spi_shifter.sv
matmul/sample_pulse_gen.sv
matmul/matmul_sequencer.sv
source/neurram_ctrl_top.sv
dv/tb_neurram_ctrl.sv

// File: Bender.yml
package:
  name: neurram_ctrl

sources:
  - files:
      - common/neurram_pkg.sv
      - source/array_mode_decode.sv
      - matmul/plane_spi_shifter.sv
      - matmul/sample_pulse_gen.sv
      - matmul/matmul_sequencer.sv
      - source/neurram_ctrl_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_neurram_ctrl.sv

// File: dv/tb_checks.svh
/*
 * testbench reference model and compare tasks
 * plane word, pulse count and array control decode from the core rules
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// reference model
// --------------------------------------------------

// bit b of every lane, lane 0 in bit 0
function automatic plane_word_t plane_of(input in_vec_t v, input int b);
	logic [NUM_LANES*LANE_BITS-1:0] flat;
	plane_word_t p;
	flat = v;
	for (int l = 0; l < NUM_LANES; l++) begin
		p[l] = flat[l*LANE_BITS + b];
	end
	return p;
endfunction

// pulses double with each higher plane
function automatic logic [PULSE_CNT_W-1:0] pulses_for(input run_cfg_t c, input int b);
	int n;
	n = c.pulse_mult * (2 ** b);
	return PULSE_CNT_W'(n);
endfunction

function automatic array_ctrl_t decode_ref(input mode_req_t m, input logic busy,
		input logic smp);
	array_ctrl_t c;
	c.inference_mode = m.inference && !m.ifat && !m.lfsr && !m.wupdate && !busy;
	c.ifat_mode      = m.ifat && !m.inference && !m.lfsr && !m.wupdate;
	c.lfsr_mode      = m.lfsr;
	c.wupdate_mode   = m.wupdate && !m.inference && !m.ifat && !m.lfsr;
	c.ext_inference_enable = c.inference_mode || c.ifat_mode || busy;
	c.ext_precharge_bl = (c.ifat_mode && !smp) || (m.inference && !m.forward && !smp);
	c.ext_precharge_sl = (c.ifat_mode && !smp) || (m.inference && m.forward && !smp);
	return c;
endfunction

// --------------------------------------------------
// compare tasks
// --------------------------------------------------
task automatic check_ctrl(input string name, input array_ctrl_t got, input array_ctrl_t exp);
	if (got !== exp) begin
		$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_plane(input string name, input plane_word_t got, input plane_word_t exp);
	if (got !== exp) begin
		$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_count(input string name, input logic [PULSE_CNT_W-1:0] got,
		input logic [PULSE_CNT_W-1:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

`endif

// File: dv/tb_neurram_ctrl.sv
/*
 * testbench for the neurram controller top
 * random runs checked against a reference model of planes, pulses and decode
 */

`timescale 1ns/1ns

module tb_neurram_ctrl
	import neurram_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_RUNS   = 30;
	// worst plane: full shift plus 31 << 3 pulses of 16 high and 16 low cycles
	localparam int PLANE_CYC  = 2*NUM_LANES + 2*(31 << (LANE_BITS-1))*(1 << T_SAMPLE_W);
	localparam int RUN_CYC    = LANE_BITS*PLANE_CYC + 64;

	logic        sys_clk;
	logic        arst_n_i;
	logic        start_i;
	run_cfg_t    cfg_i;
	in_vec_t     vec_i;
	mode_req_t   mode_i;
	logic        busy_o;
	logic        done_o;
	logic        spi_clk_o;
	logic        shift_o;
	logic        sw_in_sample_o;
	array_ctrl_t ctrl_o;

	// run under test, shared with the monitor
	run_cfg_t    cfg_run;
	in_vec_t     vec_run;
	logic        run_open;
	logic        run_live;  // start edge has passed, busy expected
	logic        mon_en;

	// monitor state
	int          bit_cnt;
	int          plane_cnt;
	plane_word_t got_plane;
	int          pulses;
	int          level_len;
	logic        low_valid; // a low phase between two pulses is being timed
	logic        prev_spi;
	logic        prev_smp;
	logic        prev_shift;

	neurram_ctrl_top UUT (.*);

	always #(CLK_PERIOD/2) sys_clk = ~sys_clk;

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	`include "tb_checks.svh"

	function automatic run_cfg_t draw_cfg();
		logic [31:0] r;
		r = $urandom;
		return r[$bits(run_cfg_t)-1:0];
	endfunction

	function automatic in_vec_t draw_vec();
		return {$urandom, $urandom};
	endfunction

	function automatic mode_req_t draw_mode();
		logic [31:0] r;
		r = $urandom;
		return r[$bits(mode_req_t)-1:0];
	endfunction

	// --------------------------------------------------
	// stimulus, all on the falling edge
	// --------------------------------------------------
	initial begin
		sys_clk      = 1'b0;
		arst_n_i     = 1'b0;
		start_i      = 1'b0;
		cfg_i        = '0;
		vec_i        = '0;
		mode_i       = '0;
		run_open     = 1'b0;
		mon_en       = 1'b0;
		void'($urandom(9));

		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		arst_n_i = 1'b1;
		mode_i   = draw_mode();
		@(negedge sys_clk);
		check_bit("busy_o", busy_o, 1'b0);
		check_bit("done_o", done_o, 1'b0);
		check_bit("spi_clk_o", spi_clk_o, 1'b0);
		check_bit("shift_o", shift_o, 1'b0);
		check_bit("sw_in_sample_o", sw_in_sample_o, 1'b0);
		check_ctrl("ctrl_o", ctrl_o, decode_ref(mode_i, 1'b0, 1'b0));
		mon_en = 1'b1;

		for (int r = 0; r < NUM_RUNS; r++) begin
			@(negedge sys_clk);
			cfg_run  = draw_cfg();
			vec_run  = draw_vec();
			cfg_i    = cfg_run;
			vec_i    = vec_run;
			mode_i   = draw_mode();
			start_i  = 1'b1;
			run_open = 1'b1;
			@(negedge sys_clk);
			start_i = 1'b0;
			cfg_i   = draw_cfg(); // capture must have happened already
			vec_i   = draw_vec();
			check_bit("busy_o after start", busy_o, 1'b1);
			while (run_open) begin
				@(negedge sys_clk);
				start_i = 1'b0;
				if ($urandom_range(7) == 0)
					mode_i = draw_mode();
				if (busy_o && $urandom_range(31) == 0) begin
					start_i = 1'b1; // must be ignored
					cfg_i   = draw_cfg();
					vec_i   = draw_vec();
				end
			end
			repeat ($urandom_range(3)) @(negedge sys_clk);
		end

		repeat (4) @(negedge sys_clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

	// --------------------------------------------------
	// monitor, samples settled outputs at the rising edge
	// --------------------------------------------------
	always @(posedge sys_clk) begin
		if (mon_en) begin
			check_bit("busy_o", busy_o, run_live && !done_o);
			if (run_open)
				run_live = 1'b1; // start taken on this edge
			check_ctrl("ctrl_o", ctrl_o, decode_ref(mode_i, busy_o, sw_in_sample_o));

			if (spi_clk_o && !prev_spi) begin
				if (!run_open) begin
					$display("spi_clk_o rose at %0t ns with no run in progress", $time);
					abort_run();
				end
				if (bit_cnt == 0) begin
					if (plane_cnt > cfg_run.planes_m1) begin
						$display("extra plane shift started at %0t ns", $time);
						abort_run();
					end
					if (plane_cnt > 0)
						check_count("sample pulse count", PULSE_CNT_W'(pulses),
							pulses_for(cfg_run, plane_cnt - 1));
					pulses    = 0;
					low_valid = 1'b0;
				end
				check_bit("shift_o held over spi_clk_o rise", shift_o, prev_shift);
				got_plane[bit_cnt] = shift_o; // lane 0 first
				bit_cnt++;
				if (bit_cnt == NUM_LANES) begin
					check_plane("shift_o plane", got_plane, plane_of(vec_run, plane_cnt));
					plane_cnt++;
					bit_cnt = 0;
				end
			end

			if (sw_in_sample_o != prev_smp) begin
				if (sw_in_sample_o) begin
					if (!run_open) begin
						$display("sw_in_sample_o rose at %0t ns with no run in progress",
							$time);
						abort_run();
					end
					pulses++;
					if (low_valid)
						check_count("sw_in_sample_o low time", PULSE_CNT_W'(level_len),
							PULSE_CNT_W'(cfg_run.t_sample_m1 + 1));
				end else begin
					check_count("sw_in_sample_o high time", PULSE_CNT_W'(level_len),
						PULSE_CNT_W'(cfg_run.t_sample_m1 + 1));
					low_valid = 1'b1;
				end
				level_len = 1;
			end else begin
				level_len++;
			end

			if (done_o) begin
				if (!run_open || plane_cnt == 0) begin
					$display("done_o pulsed at %0t ns without a finished run", $time);
					abort_run();
				end
				check_count("sample pulse count", PULSE_CNT_W'(pulses),
					pulses_for(cfg_run, plane_cnt - 1));
				check_count("plane shifts", PULSE_CNT_W'(plane_cnt),
					PULSE_CNT_W'(cfg_run.planes_m1 + 1));
				check_count("partial plane bits", PULSE_CNT_W'(bit_cnt), '0);
				plane_cnt = 0;
				pulses    = 0;
				low_valid = 1'b0;
				run_live  = 1'b0;
				run_open  = 1'b0;
			end
		end
		prev_spi   = spi_clk_o;
		prev_smp   = sw_in_sample_o;
		prev_shift = shift_o;
	end

	initial begin
		bit_cnt    = 0;
		plane_cnt  = 0;
		got_plane  = '0;
		pulses     = 0;
		level_len  = 0;
		low_valid  = 1'b0;
		run_live   = 1'b0;
		prev_spi   = 1'b0;
		prev_smp   = 1'b0;
		prev_shift = 1'b0;
	end

	// watchdog sized for every run at its longest
	initial begin
		#(CLK_PERIOD * (NUM_RUNS*RUN_CYC + 100));
		$display("watchdog expired before all runs completed");
		abort_run();
	end

endmodule

// File: source/neurram_ctrl_top.sv
/*
 * neurram controller top
 * matmul sequencing core with plane shifter, sample pulse train
 * and array mode decode
 */

`timescale 1ns/1ns

module neurram_ctrl_top
	import neurram_pkg::*;
(
	input  logic        sys_clk,
	input  logic        arst_n_i,
	input  logic        start_i,
	input  run_cfg_t    cfg_i,
	input  in_vec_t     vec_i,
	input  mode_req_t   mode_i,
	output logic        busy_o,
	output logic        done_o,
	output logic        spi_clk_o,
	output logic        shift_o,
	output logic        sw_in_sample_o,
	output array_ctrl_t ctrl_o
);

	// --------------------------------------------------
	// sequencer side
	// --------------------------------------------------
	logic                   load;
	plane_word_t            plane;
	logic                   shift_done;
	logic                   fire;
	logic [PULSE_CNT_W-1:0] pulse_cnt;
	logic [T_SAMPLE_W-1:0]  t_sample_m1;
	logic                   pulse_done;

	matmul_sequencer u_seq (
		.sys_clk       (sys_clk),
		.arst_n_i      (arst_n_i),
		.start_i       (start_i),
		.cfg_i         (cfg_i),
		.vec_i         (vec_i),
		.shift_done_i  (shift_done),
		.pulse_done_i  (pulse_done),
		.load_o        (load),
		.plane_o       (plane),
		.fire_o        (fire),
		.pulse_cnt_o   (pulse_cnt),
		.t_sample_m1_o (t_sample_m1),
		.busy_o        (busy_o),
		.done_o        (done_o)
	);

	plane_spi_shifter u_shift (
		.sys_clk   (sys_clk),
		.arst_n_i  (arst_n_i),
		.load_i    (load),
		.plane_i   (plane),
		.spi_clk_o (spi_clk_o),
		.shift_o   (shift_o),
		.done_o    (shift_done)
	);

	sample_pulse_gen u_pulse (
		.sys_clk        (sys_clk),
		.arst_n_i       (arst_n_i),
		.fire_i         (fire),
		.count_i        (pulse_cnt),
		.t_sample_m1_i  (t_sample_m1),
		.sw_in_sample_o (sw_in_sample_o),
		.done_o         (pulse_done)
	);

	// sample level doubles as the precharge release
	array_mode_decode u_decode (
		.mode_i     (mode_i),
		.seq_busy_i (busy_o),
		.sampling_i (sw_in_sample_o),
		.ctrl_o     (ctrl_o)
	);

endmodule

// File: matmul/matmul_sequencer.sv
/*
 * matmul sequencer
 * walks the bit-planes of the input vector from bit 0 upward, shifting
 * each plane into the chip and then firing a doubling train of samples
 */

`timescale 1ns/1ns

module matmul_sequencer
	import neurram_pkg::*;
(
	input  logic                   sys_clk,
	input  logic                   arst_n_i,
	input  logic                   start_i,
	input  run_cfg_t               cfg_i,
	input  in_vec_t                vec_i,
	input  logic                   shift_done_i,
	input  logic                   pulse_done_i,
	output logic                   load_o,
	output plane_word_t            plane_o,
	output logic                   fire_o,
	output logic [PULSE_CNT_W-1:0] pulse_cnt_o,
	output logic [T_SAMPLE_W-1:0]  t_sample_m1_o,
	output logic                   busy_o,
	output logic                   done_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SHIFT,
		S_PULSE,
		S_DONE
	} seq_state_t;

	seq_state_t             state;
	logic [PLANE_IDX_W-1:0] plane_idx;
	run_cfg_t               cfg_q;
	in_vec_t                vec_q;
	logic                   accept;

	// done cycle already counts as idle for the host
	assign accept = start_i & ((state == S_IDLE) | (state == S_DONE));

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= S_IDLE;
			plane_idx <= '0;
			load_o    <= 1'b0;
			fire_o    <= 1'b0;
		end else begin
			load_o <= 1'b0; // strobes
			fire_o <= 1'b0;
			case (state)
				S_IDLE, S_DONE: begin
					state <= S_IDLE;
					if (accept) begin
						state     <= S_SHIFT;
						plane_idx <= '0;
						load_o    <= 1'b1;
					end
				end
				S_SHIFT: if (shift_done_i) begin
					state  <= S_PULSE;
					fire_o <= 1'b1;
				end
				S_PULSE: if (pulse_done_i) begin
					if (plane_idx == cfg_q.planes_m1) begin
						state <= S_DONE;
					end else begin
						state     <= S_SHIFT;
						plane_idx <= plane_idx + 1'b1;
						load_o    <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// run payload, captured with the start strobe
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			cfg_q <= cfg_i;
			vec_q <= vec_i;
		end
	end

	// --------------------------------------------------
	// plane word and pulse count for current plane
	// --------------------------------------------------
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			plane_o[l] = vec_q[l][plane_idx];
		end
	end

	assign pulse_cnt_o   = PULSE_CNT_W'(cfg_q.pulse_mult) << plane_idx; // weight 2^b
	assign t_sample_m1_o = cfg_q.t_sample_m1;

	assign busy_o = (state == S_SHIFT) | (state == S_PULSE);
	assign done_o = (state == S_DONE);

endmodule

// File: matmul/sample_pulse_gen.sv
/*
 * neuron sample pulse generator
 * emits a counted train of sample pulses, each high and low
 * for a programmable number of cycles
 */

`timescale 1ns/1ns

module sample_pulse_gen
	import neurram_pkg::*;
(
	input  logic                   sys_clk,
	input  logic                   arst_n_i,
	input  logic                   fire_i,
	input  logic [PULSE_CNT_W-1:0] count_i,
	input  logic [T_SAMPLE_W-1:0]  t_sample_m1_i,
	output logic                   sw_in_sample_o,
	output logic                   done_o
);

	logic [PULSE_CNT_W-1:0] remaining; // pulses not yet finished
	logic [T_SAMPLE_W-1:0]  timer;     // cycles left in phase, minus one

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			remaining      <= '0;
			timer          <= '0;
			sw_in_sample_o <= 1'b0;
			done_o         <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (fire_i) begin
				if (count_i == '0) begin
					done_o <= 1'b1; // empty train
				end else begin
					remaining      <= count_i;
					timer          <= t_sample_m1_i;
					sw_in_sample_o <= 1'b1;
				end
			end else if (remaining != '0) begin
				if (timer != '0) begin
					timer <= timer - 1'b1;
				end else if (sw_in_sample_o) begin
					// high phase over
					sw_in_sample_o <= 1'b0;
					timer          <= t_sample_m1_i;
				end else if (remaining == PULSE_CNT_W'(1)) begin
					remaining <= '0;
					done_o    <= 1'b1;
				end else begin
					remaining      <= remaining - 1'b1;
					timer          <= t_sample_m1_i;
					sw_in_sample_o <= 1'b1; // next pulse
				end
			end
		end
	end

endmodule

// File: matmul/plane_spi_shifter.sv
/*
 * plane SPI shifter
 * serializes one bit-plane onto the chip shift line, lane 0 first,
 * two cycles per bit with the chip sampling on the rising shift clock
 */

`timescale 1ns/1ns

module plane_spi_shifter
	import neurram_pkg::*;
(
	input  logic        sys_clk,
	input  logic        arst_n_i,
	input  logic        load_i,
	input  plane_word_t plane_i,
	output logic        spi_clk_o,
	output logic        shift_o,
	output logic        done_o
);

	plane_word_t           sreg;    // bit 0 is the one on the line
	logic [LANE_IDX_W-1:0] bit_cnt;
	logic                  phase;   // 0 clock low, 1 clock high
	logic                  active;

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sreg      <= '0;
			bit_cnt   <= '0;
			phase     <= 1'b0;
			active    <= 1'b0;
			spi_clk_o <= 1'b0;
			shift_o   <= 1'b0;
			done_o    <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (load_i) begin
				sreg      <= plane_i;
				shift_o   <= plane_i[0]; // lane 0 goes out first
				spi_clk_o <= 1'b0;
				bit_cnt   <= '0;
				phase     <= 1'b0;
				active    <= 1'b1;
			end else if (active) begin
				if (!phase) begin
					spi_clk_o <= 1'b1; // chip samples here
					phase     <= 1'b1;
				end else if (bit_cnt == LANE_IDX_W'(NUM_LANES - 1)) begin
					// last bit clocked in
					spi_clk_o <= 1'b0;
					shift_o   <= 1'b0;
					active    <= 1'b0;
					done_o    <= 1'b1;
				end else begin
					sreg      <= sreg >> 1;
					shift_o   <= sreg[1];
					spi_clk_o <= 1'b0;
					bit_cnt   <= bit_cnt + 1'b1;
					phase     <= 1'b0;
				end
			end
		end
	end

endmodule

// File: source/array_mode_decode.sv
/*
 * array mode decode
 * turns the host mode request into exclusive array mode lines and
 * bit-line / source-line precharge, overridden while a multiply runs
 */

`timescale 1ns/1ns

module array_mode_decode
	import neurram_pkg::*;
(
	input  mode_req_t   mode_i,
	input  logic        seq_busy_i,
	input  logic        sampling_i,
	output array_ctrl_t ctrl_o
);

	logic prech_ifat; // ifat precharges both lines outside sampling
	logic prech_fwd;
	logic prech_bwd;

	always_comb begin
		ctrl_o = '0;

		// --------------------------------------------------
		// mode lines, one at a time
		// --------------------------------------------------
		ctrl_o.inference_mode = mode_i.inference & ~(mode_i.ifat | mode_i.lfsr | mode_i.wupdate)
			& ~seq_busy_i; // matmul turns inference off
		ctrl_o.ifat_mode      = mode_i.ifat & ~(mode_i.inference | mode_i.lfsr | mode_i.wupdate);
		ctrl_o.lfsr_mode      = mode_i.lfsr;
		ctrl_o.wupdate_mode   = mode_i.wupdate & ~(mode_i.inference | mode_i.ifat | mode_i.lfsr);

		// external enable held on for the whole multiply
		ctrl_o.ext_inference_enable = ctrl_o.inference_mode | ctrl_o.ifat_mode | seq_busy_i;

		// --------------------------------------------------
		// precharge, released while neurons sample
		// --------------------------------------------------
		prech_ifat = ctrl_o.ifat_mode & ~sampling_i;
		prech_fwd  = mode_i.inference & mode_i.forward & ~sampling_i;
		prech_bwd  = mode_i.inference & ~mode_i.forward & ~sampling_i;

		ctrl_o.ext_precharge_bl = prech_ifat | prech_bwd;
		ctrl_o.ext_precharge_sl = prech_ifat | prech_fwd;
	end

endmodule

// File: common/neurram_pkg.sv
/*
 * neurram control package
 * widths, run config, host mode request and array control line types
 * shared by the matmul sequencing core and the mode decoder
 */

package neurram_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int NUM_LANES   = 16; // input lanes, one bit each per plane
	localparam int LANE_BITS   = 4;  // bits per lane value, also max planes
	localparam int PULSE_CNT_W = 8;  // 31 << 3 still fits
	localparam int T_SAMPLE_W  = 4;
	localparam int PLANE_IDX_W = $clog2(LANE_BITS);
	localparam int LANE_IDX_W  = $clog2(NUM_LANES);

	// --------------------------------------------------
	// payload types
	// --------------------------------------------------
	typedef logic [NUM_LANES-1:0][LANE_BITS-1:0] in_vec_t; // lane 0 in low bits
	typedef logic [NUM_LANES-1:0] plane_word_t;            // bit n is lane n

	typedef struct packed {
		logic [PLANE_IDX_W-1:0] planes_m1;   // planes used minus one
		logic [4:0]             pulse_mult;  // pulses for plane 0
		logic [T_SAMPLE_W-1:0]  t_sample_m1; // high and low time minus one
	} run_cfg_t;

	// host mode request
	typedef struct packed {
		logic inference;
		logic ifat;
		logic lfsr;
		logic wupdate;
		logic forward; // forward vs backward inference direction
	} mode_req_t;

	// lines to the array
	typedef struct packed {
		logic inference_mode;
		logic ifat_mode;
		logic lfsr_mode;
		logic wupdate_mode;
		logic ext_inference_enable;
		logic ext_precharge_bl;
		logic ext_precharge_sl;
	} array_ctrl_t;

endpackage
